//--- logic/exPkg.sv
// ========================================
// Shared codes and widths for the EX back end
// Command codes outside the list act as a nop
// ========================================
package exPkg;

	localparam int dataWidth = 32;
	localparam int halfWidth = dataWidth / 2;
	localparam int wordBytes = dataWidth / 8;
	localparam int regIdWidth = 5; // Id 0 is the zero register
	localparam int holdCntWidth = 4; // Saturates at 15

	// Micro-op commands, low 6 bits of opUCmd
	localparam logic [5:0] uCmdNop = 6'h00;
	localparam logic [5:0] uCmdAlu3 = 6'h01;
	localparam logic [5:0] uCmdAluCmp = 6'h02;
	localparam logic [5:0] uCmdMul3 = 6'h03;
	localparam logic [5:0] uCmdMovIr = 6'h04;
	localparam logic [5:0] uCmdLoad = 6'h05;
	localparam logic [5:0] uCmdStore = 6'h06;
	localparam logic [5:0] uCmdSleep = 6'h07;

	// Predication, top 2 bits of opUCmd
	localparam logic [1:0] predAlways = 2'b00;
	localparam logic [1:0] predNever = 2'b01;
	localparam logic [1:0] predIfT = 2'b10;
	localparam logic [1:0] predIfF = 2'b11;

	localparam logic [3:0] aluAdd = 4'h0;
	localparam logic [3:0] aluSub = 4'h1;
	localparam logic [3:0] aluAnd = 4'h2;
	localparam logic [3:0] aluOr = 4'h3;
	localparam logic [3:0] aluXor = 4'h4;
	localparam logic [3:0] aluShl = 4'h5;
	localparam logic [3:0] aluShr = 4'h6; // Logical shift
	// Compare ops reuse the function field
	localparam logic [3:0] cmpEq = 4'h0;
	localparam logic [3:0] cmpGtSigned = 4'h1;
	localparam logic [3:0] cmpGtUnsigned = 4'h2;

	localparam logic [1:0] memSizeByte = 2'd0;
	localparam logic [1:0] memSizeHalf = 2'd1;
	localparam logic [1:0] memSizeWord = 2'd2;

	// Bit 1 set means not ready, bit 0 then tells fault from hold
	localparam logic [1:0] memOkReady = 2'b00;
	localparam logic [1:0] memOkHold = 2'b10;
	localparam logic [1:0] memOkFault = 2'b11;

	localparam int mulHoldCycles = 3; // Matches the multiplier depth
	localparam int sleepHoldCycles = 15;
	localparam int memWords = 256;
	localparam int memIdxWidth = $clog2(memWords);

	typedef struct packed {
		logic [3:0] rsvd;
		logic [3:0] func;
	} uIxtAluView;

	typedef struct packed {
		logic [4:0] rsvd;
		logic signExt; // Sign extend loads
		logic [1:0] size;
	} uIxtMemView;

	// One extension byte, read per command class
	typedef union packed {
		uIxtAluView aluView;
		uIxtMemView memView;
	} uIxtWord;

endpackage

//--- logic/exRegFile.sv
// ========================================
// 32 GPRs plus T, register 0 reads as zero
// ========================================
module exRegFile (
	input  logic clock,
	input  logic rst,
	input  logic [exPkg::regIdWidth-1:0] regIdA,
	input  logic [exPkg::regIdWidth-1:0] regIdB,
	output logic [exPkg::dataWidth-1:0] regValA,
	output logic [exPkg::dataWidth-1:0] regValB,
	input  logic [exPkg::regIdWidth-1:0] regIdW,
	input  logic [exPkg::dataWidth-1:0] regValW,
	input  logic writeEn,
	input  logic srTNext,
	input  logic srTWrite,
	output logic srT
);
	import exPkg::*;

	logic [dataWidth-1:0] regs [1 << regIdWidth];

	assign regValA = (regIdA == '0) ? '0 : regs[regIdA];
	assign regValB = (regIdB == '0) ? '0 : regs[regIdB];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < (1 << regIdWidth); i++)
				regs[i] <= '0;
			srT <= 1'b0;
		end else if (writeEn) begin // Low while EX2 holds
			if (regIdW != '0)
				regs[regIdW] <= regValW;
			if (srTWrite)
				srT <= srTNext;
		end
	end

endmodule

//--- logic/exStage1.sv
// ========================================
// EX1, predicates with T as last committed
// Source ops must stay stable while stalled
// ========================================
module exStage1 (
	input  logic clock,
	input  logic rst,
	input  logic [7:0] opUCmd,
	input  exPkg::uIxtWord opUIxt,
	input  logic [exPkg::regIdWidth-1:0] regIdRs,
	input  logic [exPkg::regIdWidth-1:0] regIdRt,
	input  logic [exPkg::regIdWidth-1:0] regIdRm,
	input  logic [exPkg::dataWidth-1:0] immValue,
	input  logic opBraFlush,
	input  logic stall,
	output logic [exPkg::regIdWidth-1:0] regIdB,
	input  logic [exPkg::dataWidth-1:0] regValA,
	input  logic [exPkg::dataWidth-1:0] regValB,
	input  logic srT,
	input  logic [exPkg::regIdWidth-1:0] regIdRn2,
	input  logic [exPkg::dataWidth-1:0] regValRn2,
	output logic [5:0] ex2UCmd,
	output exPkg::uIxtWord ex2UIxt,
	output logic [exPkg::regIdWidth-1:0] ex2RegIdRm,
	output logic [exPkg::dataWidth-1:0] ex2AluResult,
	output logic ex2AluT,
	output logic memReq,
	output logic memWrite,
	output logic [exPkg::dataWidth-1:0] memAddr,
	output logic [exPkg::dataWidth-1:0] memDataOut,
	output logic [1:0] memSize,
	output logic mulStart,
	output logic [exPkg::dataWidth-1:0] mulA,
	output logic [exPkg::dataWidth-1:0] mulB
);
	import exPkg::*;

	logic opEnable;
	logic [5:0] cmd;
	logic [dataWidth-1:0] srcA;
	logic [dataWidth-1:0] srcB;
	logic [dataWidth-1:0] aluOut;
	logic cmpT;

	assign regIdB = (opUCmd[5:0] == uCmdStore) ? regIdRm : regIdRt; // Store data from rm

	always_comb begin
		case (opUCmd[7:6])
			predAlways: opEnable = 1'b1;
			predNever: opEnable = 1'b0;
			predIfT: opEnable = srT;
			default: opEnable = !srT; // predIfF
		endcase
		if (opBraFlush)
			opEnable = 1'b0; // Flushed op becomes a bubble
		cmd = opEnable ? opUCmd[5:0] : uCmdNop;
	end

	// Bypass the EX2 writeback, id 0 never matches
	assign srcA = (regIdRs != '0 && regIdRs == regIdRn2) ? regValRn2 : regValA;
	assign srcB = (regIdB != '0 && regIdB == regIdRn2) ? regValRn2 : regValB;

	always_comb begin
		case (opUIxt.aluView.func)
			aluAdd: aluOut = srcA + srcB;
			aluSub: aluOut = srcA - srcB;
			aluAnd: aluOut = srcA & srcB;
			aluOr: aluOut = srcA | srcB;
			aluXor: aluOut = srcA ^ srcB;
			aluShl: aluOut = srcA << srcB[4:0];
			aluShr: aluOut = srcA >> srcB[4:0];
			default: aluOut = srcA;
		endcase
		case (opUIxt.aluView.func)
			cmpEq: cmpT = srcA == srcB;
			cmpGtSigned: cmpT = $signed(srcA) > $signed(srcB);
			cmpGtUnsigned: cmpT = srcA > srcB;
			default: cmpT = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			ex2UCmd <= uCmdNop;
			memReq <= 1'b0;
			memWrite <= 1'b0;
			mulStart <= 1'b0;
		end else if (!stall) begin
			ex2UCmd <= cmd;
			memReq <= cmd == uCmdLoad || cmd == uCmdStore;
			memWrite <= cmd == uCmdStore;
			mulStart <= cmd == uCmdMul3;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			ex2UIxt <= opUIxt;
			ex2RegIdRm <= regIdRm;
			ex2AluResult <= (cmd == uCmdMovIr) ? immValue : aluOut; // Imm rides the ALU path
			ex2AluT <= cmpT;
			memAddr <= srcA + immValue; // Base plus displacement
			memDataOut <= srcB;
			memSize <= opUIxt.memView.size;
			mulA <= srcA;
			mulB <= srcB;
		end
	end

	// Source keeps the op steady while EX2 holds
	heldOpStable: assert property (@(posedge clock) disable iff (rst)
		stall |=> $stable(opUCmd) && $stable(opUIxt) && $stable(regIdRs)
			&& $stable(regIdRt) && $stable(regIdRm) && $stable(immValue)
			&& $stable(opBraFlush));

endmodule

//--- logic/exStage2.sv
// ========================================
// EX2, memory ops hold for at least a cycle
// Faulting accesses drop their writeback
// ========================================
module exStage2 (
	input  logic clock,
	input  logic rst,
	input  logic [5:0] ex2UCmd,
	input  exPkg::uIxtWord ex2UIxt,
	input  logic [exPkg::regIdWidth-1:0] ex2RegIdRm,
	input  logic [exPkg::dataWidth-1:0] ex2AluResult,
	input  logic ex2AluT,
	input  logic [exPkg::dataWidth-1:0] mulResult,
	input  logic [exPkg::dataWidth-1:0] memDataIn,
	input  logic [1:0] memDataOK,
	output logic [1:0] exHold,
	output logic [exPkg::regIdWidth-1:0] regIdRn2,
	output logic [exPkg::dataWidth-1:0] regValRn2,
	output logic srTNext,
	output logic srTWrite,
	output logic memFault
);
	import exPkg::*;

	logic tExHold;
	logic memOp;
	logic memHold;
	logic memErr;
	logic [holdCntWidth-1:0] holdCnt;
	logic [holdCntWidth-1:0] needCycles;
	logic [dataWidth-1:0] loadVal;

	// Memory returns the addressed lanes at the bottom
	always_comb begin
		case (ex2UIxt.memView.size)
			memSizeByte: loadVal = {{(dataWidth - 8){ex2UIxt.memView.signExt & memDataIn[7]}},
				memDataIn[7:0]};
			memSizeHalf: loadVal = {{halfWidth{ex2UIxt.memView.signExt & memDataIn[15]}},
				memDataIn[halfWidth-1:0]};
			default: loadVal = memDataIn;
		endcase
	end

	always_comb begin
		regIdRn2 = '0; // No writeback by default
		regValRn2 = ex2AluResult;
		srTNext = ex2AluT;
		srTWrite = 1'b0;
		needCycles = '0;
		memOp = 1'b0;
		case (ex2UCmd)
			uCmdAlu3, uCmdMovIr: begin
				regIdRn2 = ex2RegIdRm;
			end
			uCmdAluCmp: begin
				srTWrite = 1'b1;
			end
			uCmdMul3: begin
				needCycles = holdCntWidth'(mulHoldCycles);
				regIdRn2 = ex2RegIdRm;
				regValRn2 = mulResult; // Valid once the hold drops
			end
			uCmdLoad: begin
				memOp = 1'b1;
				needCycles = holdCntWidth'(1);
				regIdRn2 = ex2RegIdRm;
				regValRn2 = loadVal;
			end
			uCmdStore: begin
				memOp = 1'b1;
				needCycles = holdCntWidth'(1);
			end
			uCmdSleep: begin
				needCycles = holdCntWidth'(sleepHoldCycles);
			end
			default: begin
			end
		endcase
		memHold = memOp && memDataOK == memOkHold;
		memErr = memOp && memDataOK == memOkFault;
		if (memErr)
			regIdRn2 = '0; // Destination left untouched
		tExHold = holdCnt < needCycles || memHold;
		memFault = memErr && !tExHold; // Release cycle only, one pulse
	end

	assign exHold = {memHold, tExHold};

	always_ff @(posedge clock) begin
		if (rst)
			holdCnt <= '0;
		else if (!tExHold)
			holdCnt <= '0;
		else if (holdCnt != '1)
			holdCnt <= holdCnt + 1'b1; // Saturating
	end

	// A hold always ends before the counter saturates
	holdBelowSaturation: assert property (@(posedge clock) disable iff (rst)
		tExHold |-> holdCnt != '1);

endmodule

//--- logic/exMulUnit.sv
// ========================================
// 3-cycle multiplier, low 32 product bits
// ========================================
module exMulUnit (
	input  logic clock,
	input  logic rst,
	input  logic stall,
	input  logic mulStart,
	input  logic [exPkg::dataWidth-1:0] mulA,
	input  logic [exPkg::dataWidth-1:0] mulB,
	output logic [exPkg::dataWidth-1:0] mulResult
);
	import exPkg::*;

	logic launch;
	logic [2:0] stageValid;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] partLow;
	logic [halfWidth-1:0] partCross; // Only the low half reaches the result
	logic [dataWidth-1:0] product;

	assign launch = mulStart && stall; // Release cycle repeats the same op, skip it

	always_ff @(posedge clock) begin
		if (rst)
			stageValid <= '0;
		else
			stageValid <= {stageValid[1:0], launch};
	end

	always_ff @(posedge clock) begin
		if (launch) begin
			opA <= mulA;
			opB <= mulB;
		end
		partLow <= opA[halfWidth-1:0] * opB[halfWidth-1:0];
		partCross <= opA[halfWidth-1:0] * opB[dataWidth-1:halfWidth]
			+ opA[dataWidth-1:halfWidth] * opB[halfWidth-1:0];
		product <= partLow + {partCross, {halfWidth{1'b0}}};
	end

	assign mulResult = stageValid[2] ? product : '0; // Drained pipe reads zero

endmodule

//--- logic/exDataMem.sv
// ========================================
// Data RAM, latency from addr[3:2], 0 is same cycle
// Request must stay stable while it holds
// ========================================
module exDataMem (
	input  logic clock,
	input  logic rst,
	input  logic memReq,
	input  logic memWrite,
	input  logic [exPkg::dataWidth-1:0] memAddr,
	input  logic [exPkg::dataWidth-1:0] memDataOut,
	input  logic [1:0] memSize,
	output logic [exPkg::dataWidth-1:0] memDataIn,
	output logic [1:0] memDataOK
);
	import exPkg::*;

	logic [dataWidth-1:0] mem [memWords];
	logic busy;
	logic [1:0] remain; // Wait cycles left
	logic done;
	logic misaligned;
	logic [wordBytes-1:0] laneMask;
	logic [dataWidth-1:0] laneData;
	logic [memIdxWidth-1:0] wordIdx;

	assign wordIdx = memAddr[memIdxWidth+1:2];
	assign done = busy ? remain == 2'd0 : memAddr[3:2] == 2'd0;

	always_comb begin
		case (memSize)
			memSizeByte: begin
				misaligned = 1'b0;
				laneMask = wordBytes'(4'b0001) << memAddr[1:0];
			end
			memSizeHalf: begin
				misaligned = memAddr[0];
				laneMask = wordBytes'(4'b0011) << memAddr[1:0];
			end
			default: begin
				misaligned = |memAddr[1:0];
				laneMask = '1;
			end
		endcase
		if (!memReq)
			memDataOK = memOkReady;
		else if (!done)
			memDataOK = memOkHold;
		else
			memDataOK = misaligned ? memOkFault : memOkReady;
	end

	assign laneData = memDataOut << {memAddr[1:0], 3'b000}; // Move to byte lane
	assign memDataIn = mem[wordIdx] >> {memAddr[1:0], 3'b000}; // Addressed lanes at the bottom

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			remain <= 2'd0;
		end else if (memReq && !done) begin
			busy <= 1'b1;
			remain <= busy ? remain - 2'd1 : memAddr[3:2] - 2'd1;
		end else begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (memReq && memWrite && done && !misaligned) begin
			for (int i = 0; i < wordBytes; i++)
				if (laneMask[i])
					mem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
		end
	end

	// EX1 must keep the request while we hold it off
	holdKeepsRequest: assert property (@(posedge clock) disable iff (rst)
		memReq && !done |=> memReq && $stable(memAddr) && $stable(memWrite)
			&& $stable(memSize) && $stable(memDataOut));

endmodule

//--- logic/exCore.sv
// ========================================
// EX back end top, inputs held while exHold set
// ========================================
module exCore (
	input  logic clock,
	input  logic rst,
	input  logic [7:0] opUCmd,
	input  exPkg::uIxtWord opUIxt,
	input  logic [exPkg::regIdWidth-1:0] regIdRs,
	input  logic [exPkg::regIdWidth-1:0] regIdRt,
	input  logic [exPkg::regIdWidth-1:0] regIdRm,
	input  logic [exPkg::dataWidth-1:0] immValue,
	input  logic opBraFlush,
	output logic [1:0] exHold,
	output logic [exPkg::regIdWidth-1:0] regIdRn2,
	output logic [exPkg::dataWidth-1:0] regValRn2,
	output logic srT,
	output logic memFault
);
	import exPkg::*;

	logic [regIdWidth-1:0] regIdB;
	logic [dataWidth-1:0] regValA;
	logic [dataWidth-1:0] regValB;
	logic srTNext;
	logic srTWrite;
	logic [5:0] ex2UCmd;
	uIxtWord ex2UIxt;
	logic [regIdWidth-1:0] ex2RegIdRm;
	logic [dataWidth-1:0] ex2AluResult;
	logic ex2AluT;
	logic memReq;
	logic memWrite;
	logic [dataWidth-1:0] memAddr;
	logic [dataWidth-1:0] memDataOut;
	logic [1:0] memSize;
	logic [dataWidth-1:0] memDataIn;
	logic [1:0] memDataOK;
	logic mulStart;
	logic [dataWidth-1:0] mulA;
	logic [dataWidth-1:0] mulB;
	logic [dataWidth-1:0] mulResult;

	exRegFile i_exRegFile (
		.clock(clock), .rst(rst),
		.regIdA(regIdRs), .regIdB(regIdB),
		.regValA(regValA), .regValB(regValB),
		.regIdW(regIdRn2), .regValW(regValRn2),
		.writeEn(!exHold[0]), // Commit only on a free edge
		.srTNext(srTNext), .srTWrite(srTWrite), .srT(srT)
	);

	exStage1 i_exStage1 (
		.clock(clock), .rst(rst),
		.opUCmd(opUCmd), .opUIxt(opUIxt),
		.regIdRs(regIdRs), .regIdRt(regIdRt), .regIdRm(regIdRm),
		.immValue(immValue), .opBraFlush(opBraFlush), .stall(exHold[0]),
		.regIdB(regIdB), .regValA(regValA), .regValB(regValB), .srT(srT),
		.regIdRn2(regIdRn2), .regValRn2(regValRn2),
		.ex2UCmd(ex2UCmd), .ex2UIxt(ex2UIxt), .ex2RegIdRm(ex2RegIdRm),
		.ex2AluResult(ex2AluResult), .ex2AluT(ex2AluT),
		.memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
		.memDataOut(memDataOut), .memSize(memSize),
		.mulStart(mulStart), .mulA(mulA), .mulB(mulB)
	);

	exStage2 i_exStage2 (
		.clock(clock), .rst(rst),
		.ex2UCmd(ex2UCmd), .ex2UIxt(ex2UIxt), .ex2RegIdRm(ex2RegIdRm),
		.ex2AluResult(ex2AluResult), .ex2AluT(ex2AluT),
		.mulResult(mulResult), .memDataIn(memDataIn), .memDataOK(memDataOK),
		.exHold(exHold), .regIdRn2(regIdRn2), .regValRn2(regValRn2),
		.srTNext(srTNext), .srTWrite(srTWrite), .memFault(memFault)
	);

	exMulUnit i_exMulUnit (
		.clock(clock), .rst(rst), .stall(exHold[0]),
		.mulStart(mulStart), .mulA(mulA), .mulB(mulB),
		.mulResult(mulResult)
	);

	exDataMem i_exDataMem (
		.clock(clock), .rst(rst),
		.memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
		.memDataOut(memDataOut), .memSize(memSize),
		.memDataIn(memDataIn), .memDataOK(memDataOK)
	);

endmodule

//--- tb/exCoreTb.sv
// ========================================
// Directed exCore tests against a register and byte memory model
// Loads only read bytes that an earlier store has written
// ========================================
module exCoreTb;
	timeunit 1ns;
	timeprecision 100ps;
	import exPkg::*;

	localparam int clockPeriod = 4;
	localparam int resetCycles = 8;
	localparam int opBudget = 80; // Upper bound on ops issued by all tests
	localparam int watchdogCycles = resetCycles + opBudget * (sleepHoldCycles + 1) + 40;

	logic clock;
	logic rst;
	logic [7:0] opUCmd;
	uIxtWord opUIxt;
	logic [regIdWidth-1:0] regIdRs;
	logic [regIdWidth-1:0] regIdRt;
	logic [regIdWidth-1:0] regIdRm;
	logic [dataWidth-1:0] immValue;
	logic opBraFlush;
	logic [1:0] exHold;
	logic [regIdWidth-1:0] regIdRn2;
	logic [dataWidth-1:0] regValRn2;
	logic srT;
	logic memFault;

	logic [dataWidth-1:0] regModel [1 << regIdWidth];
	logic tModel; // T as committed
	logic [7:0] memModel [4 * memWords];
	int errors;
	integer seed;
	int holdCycles; // Hold seen for the op in EX2
	int memHoldCycles;
	int earlyFaults;

	// Op sitting in EX2, checked once its hold ends
	logic pendValid;
	logic [1:0] pendPred;
	logic [5:0] pendCode;
	uIxtWord pendIxt;
	logic [regIdWidth-1:0] pendRs;
	logic [regIdWidth-1:0] pendRt;
	logic [regIdWidth-1:0] pendRm;
	logic [dataWidth-1:0] pendImm;
	logic pendFlush;
	logic pendT; // T that EX1 saw for it

	exCore i_exCore (
		.clock(clock), .rst(rst),
		.opUCmd(opUCmd), .opUIxt(opUIxt),
		.regIdRs(regIdRs), .regIdRt(regIdRt), .regIdRm(regIdRm),
		.immValue(immValue), .opBraFlush(opBraFlush),
		.exHold(exHold), .regIdRn2(regIdRn2), .regValRn2(regValRn2),
		.srT(srT), .memFault(memFault)
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	initial begin
		#(watchdogCycles * clockPeriod);
		$display("Watchdog expired after %0d cycles, the DUT stopped advancing", watchdogCycles);
		$display("Test FAILED");
		$finish;
	end

	task automatic checkData(input string name, input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkId(input string name, input logic [regIdWidth-1:0] got,
		input logic [regIdWidth-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp) begin
			errors++;
			$display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	function automatic logic [dataWidth-1:0] aluRef(input logic [3:0] func,
		input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		case (func)
			aluAdd: return a + b;
			aluSub: return a - b;
			aluAnd: return a & b;
			aluOr: return a | b;
			aluXor: return a ^ b;
			aluShl: return a << b[4:0]; // Shift amount from low 5 bits
			aluShr: return a >> b[4:0];
			default: return a;
		endcase
	endfunction

	function automatic logic cmpRef(input logic [3:0] func,
		input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		case (func)
			cmpEq: return a == b;
			cmpGtSigned: return $signed(a) > $signed(b);
			cmpGtUnsigned: return a > b;
			default: return 1'b0;
		endcase
	endfunction

	// Little endian read, then extend from the top loaded byte
	function automatic logic [dataWidth-1:0] loadRef(input int idx, input int nBytes,
		input logic sext);
		logic [dataWidth-1:0] val;
		int i;
		val = '0;
		for (i = 0; i < nBytes; i++)
			val[8*i +: 8] = memModel[idx + i];
		if (sext && val[8*nBytes-1])
			for (i = nBytes; i < 4; i++)
				val[8*i +: 8] = 8'hFF;
		return val;
	endfunction

	task automatic checkPending();
		logic enabled;
		logic [5:0] cmd;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] addr;
		logic [dataWidth-1:0] expVal;
		logic [regIdWidth-1:0] expId;
		logic expFault;
		int expHold;
		int expMemHold;
		int nBytes;
		int idx;
		int i;
		case (pendPred)
			predAlways: enabled = 1'b1;
			predNever: enabled = 1'b0;
			predIfT: enabled = pendT;
			default: enabled = !pendT;
		endcase
		cmd = (enabled && !pendFlush) ? pendCode : uCmdNop; // Disabled op is a bubble
		a = regModel[pendRs];
		b = (cmd == uCmdStore) ? regModel[pendRm] : regModel[pendRt]; // Store data is rm
		addr = a + pendImm;
		idx = int'(addr[memIdxWidth+1:0]);
		case (pendIxt.memView.size)
			memSizeByte: nBytes = 1;
			memSizeHalf: nBytes = 2;
			default: nBytes = 4;
		endcase
		expId = '0;
		expVal = '0;
		expFault = 1'b0;
		expHold = 0;
		expMemHold = 0;
		if (cmd == uCmdLoad || cmd == uCmdStore) begin
			expMemHold = int'(addr[3:2]);
			expHold = (expMemHold > 1) ? expMemHold : 1; // At least one cycle
			expFault = (idx % nBytes) != 0;
		end
		case (cmd)
			uCmdAlu3: begin
				expId = pendRm;
				expVal = aluRef(pendIxt.aluView.func, a, b);
			end
			uCmdMovIr: begin
				expId = pendRm;
				expVal = pendImm;
			end
			uCmdMul3: begin
				expId = pendRm;
				expVal = a * b; // Low word of the product
				expHold = mulHoldCycles;
			end
			uCmdSleep: expHold = sleepHoldCycles;
			uCmdLoad: begin
				if (!expFault) begin
					expId = pendRm;
					expVal = loadRef(idx, nBytes, pendIxt.memView.signExt);
				end
			end
			default: begin
			end
		endcase
		checkId("regIdRn2", regIdRn2, expId);
		if (expId != '0)
			checkData("regValRn2", regValRn2, expVal);
		checkBit("srT", srT, tModel);
		checkBit("memFault", memFault, expFault); // Pulse lands on the release cycle
		checkCount("exHold[0] cycles", holdCycles, expHold);
		checkCount("exHold[1] cycles", memHoldCycles, expMemHold);
		if (earlyFaults != 0) begin
			errors++;
			$display("memFault was high %0d times before the hold ended", earlyFaults);
		end
		// Same effects the DUT commits on the next edge
		if (expId != '0)
			regModel[expId] = expVal;
		if (cmd == uCmdAluCmp)
			tModel = cmpRef(pendIxt.aluView.func, a, b);
		if (cmd == uCmdStore && !expFault)
			for (i = 0; i < nBytes; i++)
				memModel[idx + i] = b[8*i +: 8];
	endtask

	// Drive one op, wait out the hold of the op ahead, then check that op
	task automatic sendOp(input logic [1:0] pred, input logic [5:0] code, input uIxtWord ixt,
		input logic [regIdWidth-1:0] rs, input logic [regIdWidth-1:0] rt,
		input logic [regIdWidth-1:0] rm, input logic [dataWidth-1:0] imm, input logic flush);
		logic tSeen;
		tSeen = tModel; // Op ahead is still uncommitted
		@(posedge clock);
		opUCmd <= {pred, code};
		opUIxt <= ixt;
		regIdRs <= rs;
		regIdRt <= rt;
		regIdRm <= rm;
		immValue <= imm;
		opBraFlush <= flush;
		holdCycles = 0;
		memHoldCycles = 0;
		earlyFaults = 0;
		@(negedge clock);
		while (exHold[0]) begin
			holdCycles++;
			if (exHold[1])
				memHoldCycles++;
			if (memFault)
				earlyFaults++;
			@(negedge clock);
		end
		if (pendValid)
			checkPending();
		pendValid = 1'b1;
		pendPred = pred;
		pendCode = code;
		pendIxt = ixt;
		pendRs = rs;
		pendRt = rt;
		pendRm = rm;
		pendImm = imm;
		pendFlush = flush;
		pendT = tSeen;
	endtask

	function automatic uIxtWord aluExt(input logic [3:0] func);
		uIxtWord w;
		w = '0;
		w.aluView.func = func;
		return w;
	endfunction

	function automatic uIxtWord memExt(input logic [1:0] size, input logic sext);
		uIxtWord w;
		w = '0;
		w.memView.size = size;
		w.memView.signExt = sext;
		return w;
	endfunction

	task automatic predMov(input logic [1:0] pred, input int rd,
		input logic [dataWidth-1:0] imm, input logic flush);
		sendOp(pred, uCmdMovIr, aluExt(aluAdd), '0, '0, regIdWidth'(rd), imm, flush);
	endtask

	task automatic movImm(input int rd, input logic [dataWidth-1:0] imm);
		predMov(predAlways, rd, imm, 1'b0);
	endtask

	task automatic aluOp(input logic [3:0] func, input int rd, input int ra, input int rb);
		sendOp(predAlways, uCmdAlu3, aluExt(func), regIdWidth'(ra), regIdWidth'(rb),
			regIdWidth'(rd), '0, 1'b0);
	endtask

	task automatic cmpOp(input logic [3:0] func, input int ra, input int rb);
		sendOp(predAlways, uCmdAluCmp, aluExt(func), regIdWidth'(ra), regIdWidth'(rb),
			'0, '0, 1'b0);
	endtask

	task automatic mulOp(input int rd, input int ra, input int rb);
		sendOp(predAlways, uCmdMul3, '0, regIdWidth'(ra), regIdWidth'(rb),
			regIdWidth'(rd), '0, 1'b0);
	endtask

	task automatic loadOp(input logic [1:0] size, input logic sext, input int rd,
		input int base, input logic [dataWidth-1:0] off);
		sendOp(predAlways, uCmdLoad, memExt(size, sext), regIdWidth'(base), '0,
			regIdWidth'(rd), off, 1'b0);
	endtask

	task automatic storeOp(input logic [1:0] size, input int base,
		input logic [dataWidth-1:0] off, input int rdata);
		sendOp(predAlways, uCmdStore, memExt(size, 1'b0), regIdWidth'(base), '0,
			regIdWidth'(rdata), off, 1'b0);
	endtask

	task automatic nopOp();
		sendOp(predAlways, uCmdNop, '0, '0, '0, '0, '0, 1'b0);
	endtask

	task automatic testReset();
		@(negedge clock);
		checkBit("exHold[0]", exHold[0], 1'b0);
		checkBit("exHold[1]", exHold[1], 1'b0);
		checkBit("memFault", memFault, 1'b0);
		checkId("regIdRn2", regIdRn2, '0);
	endtask

	task automatic testAlu();
		movImm(1, $random(seed));
		movImm(2, $random(seed));
		movImm(3, $random(seed));
		aluOp(aluAdd, 4, 1, 3); // r3 comes from the bypass
		aluOp(aluSub, 5, 4, 1);
		aluOp(aluAnd, 6, 5, 2);
		aluOp(aluOr, 7, 6, 1);
		aluOp(aluXor, 8, 7, 5);
		aluOp(aluShl, 9, 8, 3);
		aluOp(aluShr, 10, 9, 3);
		aluOp(aluAdd, 11, 10, 0); // r0 reads zero
	endtask

	task automatic testPredication();
		movImm(12, 32'd5);
		movImm(13, 32'd9);
		cmpOp(cmpGtUnsigned, 13, 12); // T set
		nopOp(); // Gives T a cycle to commit
		predMov(predIfT, 14, $random(seed), 1'b0);
		predMov(predIfF, 15, $random(seed), 1'b0);
		cmpOp(cmpEq, 12, 13); // T clear
		nopOp();
		predMov(predIfT, 16, $random(seed), 1'b0);
		predMov(predIfF, 17, $random(seed), 1'b0);
		predMov(predNever, 18, $random(seed), 1'b0);
		predMov(predAlways, 19, $random(seed), 1'b1); // Flushed
		movImm(20, 32'hFFFF_FFFF);
		cmpOp(cmpGtSigned, 12, 20);
		predMov(predIfT, 21, $random(seed), 1'b0); // Sees T before the compare commits
		cmpOp(cmpGtUnsigned, 12, 20);
		nopOp();
		aluOp(aluOr, 22, 18, 19); // Never written, still zero
		aluOp(aluOr, 23, 14, 15);
	endtask

	task automatic testMulSleep();
		movImm(24, $random(seed));
		movImm(25, $random(seed));
		mulOp(26, 24, 25);
		mulOp(27, 26, 24); // Product forwarded from EX2
		sleepOp();
		aluOp(aluAdd, 28, 26, 27);
	endtask

	task automatic sleepOp();
		sendOp(predAlways, uCmdSleep, '0, '0, '0, '0, '0, 1'b0);
	endtask

	task automatic testMemory();
		movImm(1, 32'h100);
		movImm(2, $random(seed));
		movImm(3, 32'h80F1_7F01);
		storeOp(memSizeWord, 1, 32'd0, 2); // Addr bits 3:2 give latency 0..3
		storeOp(memSizeWord, 1, 32'd4, 3);
		storeOp(memSizeWord, 1, 32'd8, 2);
		storeOp(memSizeWord, 1, 32'd12, 3);
		loadOp(memSizeWord, 1'b0, 4, 1, 32'd4);
		loadOp(memSizeByte, 1'b1, 5, 1, 32'd5);
		loadOp(memSizeByte, 1'b1, 6, 1, 32'd14); // 0xF1, negative
		loadOp(memSizeByte, 1'b0, 7, 1, 32'd15);
		loadOp(memSizeHalf, 1'b1, 8, 1, 32'd14);
		loadOp(memSizeHalf, 1'b0, 9, 1, 32'd6);
		storeOp(memSizeByte, 1, 32'd1, 3);
		storeOp(memSizeHalf, 1, 32'd2, 3);
		loadOp(memSizeWord, 1'b0, 10, 1, 32'd0);
		loadOp(memSizeWord, 1'b0, 4, 1, 32'd2); // Misaligned, r4 kept
		loadOp(memSizeHalf, 1'b1, 5, 1, 32'd13); // Misaligned at latency 3
		storeOp(memSizeHalf, 1, 32'd9, 2); // Misaligned store drops its data
		loadOp(memSizeWord, 1'b0, 11, 1, 32'd8);
		aluOp(aluOr, 12, 4, 5);
	endtask

	initial begin
		int i;
		errors = 0;
		seed = 37561;
		tModel = 1'b0;
		pendValid = 1'b0;
		for (i = 0; i < (1 << regIdWidth); i++)
			regModel[i] = '0;
		rst = 1'b1;
		opUCmd = '0;
		opUIxt = '0;
		regIdRs = '0;
		regIdRt = '0;
		regIdRm = '0;
		immValue = '0;
		opBraFlush = 1'b0;
		repeat (resetCycles) @(posedge clock);
		rst <= 1'b0;
		testReset();
		testAlu();
		testPredication();
		testMulSleep();
		testMemory();
		nopOp(); // Retires the last real op
		nopOp();
		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

//--- all.f
logic/exPkg.sv
logic/exRegFile.sv
logic/exStage1.sv
logic/exStage2.sv
logic/exMulUnit.sv
logic/exDataMem.sv
logic/exCore.sv
tb/exCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the exCore testbench with Verilator, runs it, scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module exCoreTb -f all.f -o exCoreSim \
	> build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/exCoreSim > sim.log 2>&1 || { cat sim.log; echo "Simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
